/* rtl/ppu_pkg.sv */
// background-only ppu, no sprites/window/dma; all registers reset to zero (no boot values)
package ppu_pkg;

    // line and frame timing in dots
    localparam int DOTS_PER_LINE           = 456;
    localparam int SCAN_DOTS               = 80;   // oam scan kept as idle dots
    localparam int SCREEN_WIDTH            = 160;
    localparam int DEFAULT_VISIBLE_LINES   = 144;
    localparam int DEFAULT_LINES_PER_FRAME = 154;

    // vram layout
    localparam logic [15:0] TILE_DATA_UNSIGNED_BASE = 16'h8000;
    localparam logic [15:0] TILE_DATA_SIGNED_BASE   = 16'h9000;   // index 0 sits mid-block
    localparam logic [15:0] MAP_LOW_BASE            = 16'h9800;
    localparam logic [15:0] MAP_HIGH_BASE           = 16'h9C00;

    // register map
    localparam logic [15:0] REG_LCDC = 16'hFF40;
    localparam logic [15:0] REG_STAT = 16'hFF41;
    localparam logic [15:0] REG_SCY  = 16'hFF42;
    localparam logic [15:0] REG_SCX  = 16'hFF43;
    localparam logic [15:0] REG_LY   = 16'hFF44;
    localparam logic [15:0] REG_LYC  = 16'hFF45;
    localparam logic [15:0] REG_BGP  = 16'hFF47;

    // mode code as read back in STAT[1:0]
    typedef enum logic [1:0] {
        mode_hblank = 2'd0,
        mode_vblank = 2'd1,
        mode_scan   = 2'd2,
        mode_draw   = 2'd3
    } ppu_mode_e;

    typedef struct packed {
        logic lcd_on;          // bit 7
        logic win_map;         // no window in this design
        logic win_on;
        logic tile_data_sel;   // 1: unsigned from 8000h
        logic bg_map_sel;      // 1: map at 9c00h
        logic obj_size;        // no sprites
        logic obj_on;
        logic bg_on;           // bit 0
    } lcdc_t;

    typedef struct packed {
        lcdc_t      lcdc;
        logic [7:0] scy;
        logic [7:0] scx;
        logic [7:0] bgp;
    } ppu_cfg_t;

    typedef struct packed {
        ppu_mode_e  mode;
        logic [7:0] ly;
        logic       line_start;   // one cycle at dot 0
    } line_status_t;

    // one tile row, two bit planes
    typedef struct packed {
        logic [7:0] lo;
        logic [7:0] hi;
    } bg_row_t;

    // map byte, decoded per LCDC bit 4
    typedef union packed {
        logic [7:0]        idx_u;
        logic signed [7:0] idx_s;
    } tile_index_u;

endpackage

/* rtl/ppu_regs.sv */
// register bus: one-cycle write, combinational read while rd high; LY read-only, STAT bits 2..0 live
`timescale 1ns/100ps

module ppu_regs (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [15:0]           addr,
    input  logic                  wr,
    input  logic                  rd,
    input  logic [7:0]            wdata,
    input  ppu_pkg::line_status_t status,
    output logic [7:0]            rdata,
    output ppu_pkg::ppu_cfg_t     cfg,
    output logic                  irq_vblank,
    output logic                  irq_stat
);

    ppu_pkg::lcdc_t lcdc;
    logic [6:3]     stat_en;   // lyc, scan, vblank, hblank interrupt enables
    logic [7:0]     scy;
    logic [7:0]     scx;
    logic [7:0]     lyc;
    logic [7:0]     bgp;
    logic           coincidence;
    logic [7:0]     stat_rd;

    always_ff @(posedge clk) begin
        if (rst) begin
            lcdc    <= '0;
            stat_en <= '0;
            scy     <= '0;
            scx     <= '0;
            lyc     <= '0;
            bgp     <= '0;
        end else if (wr) begin
            case (addr)
                ppu_pkg::REG_LCDC: lcdc    <= ppu_pkg::lcdc_t'(wdata);
                ppu_pkg::REG_STAT: stat_en <= wdata[6:3];   // low bits are status
                ppu_pkg::REG_SCY:  scy     <= wdata;
                ppu_pkg::REG_SCX:  scx     <= wdata;
                ppu_pkg::REG_LYC:  lyc     <= wdata;
                ppu_pkg::REG_BGP:  bgp     <= wdata;
                default: ;                                  // LY and unmapped ignore writes
            endcase
        end
    end

    assign coincidence = (status.ly == lyc);
    assign stat_rd     = {1'b1, stat_en, coincidence, status.mode};

    always_comb begin
        rdata = 8'hFF;
        if (rd) begin
            case (addr)
                ppu_pkg::REG_LCDC: rdata = lcdc;
                ppu_pkg::REG_STAT: rdata = stat_rd;
                ppu_pkg::REG_SCY:  rdata = scy;
                ppu_pkg::REG_SCX:  rdata = scx;
                ppu_pkg::REG_LY:   rdata = status.ly;   // live line counter
                ppu_pkg::REG_LYC:  rdata = lyc;
                ppu_pkg::REG_BGP:  rdata = bgp;
                default:           rdata = 8'hFF;
            endcase
        end
    end

    assign cfg.lcdc = lcdc;
    assign cfg.scy  = scy;
    assign cfg.scx  = scx;
    assign cfg.bgp  = bgp;

    assign irq_vblank = (status.mode == ppu_pkg::mode_vblank);

    // level, not edge: stays high while any enabled source holds
    assign irq_stat = (stat_en[6] && coincidence)
                    || (stat_en[3] && status.mode == ppu_pkg::mode_hblank)
                    || (stat_en[4] && status.mode == ppu_pkg::mode_vblank)
                    || (stat_en[5] && status.mode == ppu_pkg::mode_scan);

    // the cpu side never reads and writes in one bus cycle
    a_no_rd_wr: assert property (@(posedge clk) disable iff (rst) !(wr && rd));

endmodule

/* rtl/ppu_line_timer.sv */
// one dot per clock while lcd_on; draw ends on line_done, so it must arrive before dot 455
`timescale 1ns/100ps

module ppu_line_timer #(
    parameter int VISIBLE_LINES   = ppu_pkg::DEFAULT_VISIBLE_LINES,
    parameter int LINES_PER_FRAME = ppu_pkg::DEFAULT_LINES_PER_FRAME
) (
    input  logic                  clk,
    input  logic                  rst,
    input  ppu_pkg::ppu_cfg_t     cfg,
    input  logic                  line_done,
    output ppu_pkg::line_status_t status
);

    logic [8:0]         dot;
    logic [7:0]         ly;
    logic [7:0]         ly_next;
    ppu_pkg::ppu_mode_e mode;
    logic               line_start;
    logic               waking;

    assign ly_next = (ly == 8'(LINES_PER_FRAME - 1)) ? 8'd0 : ly + 8'd1;
    // dot 0 without a line_start only happens after reset or lcd off
    assign waking  = (dot == 9'd0) && !line_start;

    always_ff @(posedge clk) begin
        if (rst) begin
            dot        <= '0;
            ly         <= '0;
            mode       <= ppu_pkg::mode_scan;
            line_start <= 1'b0;
        end else if (!cfg.lcdc.lcd_on) begin
            dot        <= '0;   // held at 0/0/hblank while off
            ly         <= '0;
            mode       <= ppu_pkg::mode_hblank;
            line_start <= 1'b0;
        end else if (waking) begin
            mode       <= ppu_pkg::mode_scan;   // line 0 starts next cycle
            line_start <= 1'b1;
        end else if (dot == 9'(ppu_pkg::DOTS_PER_LINE - 1)) begin
            dot        <= '0;
            ly         <= ly_next;
            line_start <= 1'b1;
            mode       <= (ly_next < VISIBLE_LINES) ? ppu_pkg::mode_scan : ppu_pkg::mode_vblank;
        end else begin
            dot        <= dot + 9'd1;
            line_start <= 1'b0;
            if (mode == ppu_pkg::mode_scan && dot == 9'(ppu_pkg::SCAN_DOTS - 1)) begin
                mode <= ppu_pkg::mode_draw;
            end else if (mode == ppu_pkg::mode_draw && line_done) begin
                mode <= ppu_pkg::mode_hblank;
            end
        end
    end

    assign status.mode       = mode;
    assign status.ly         = ly;
    assign status.line_start = line_start;

    a_no_draw_in_vblank: assert property (@(posedge clk) disable iff (rst)
        (mode == ppu_pkg::mode_draw) |-> (ly < VISIBLE_LINES));

    a_dot_range: assert property (@(posedge clk) disable iff (rst)
        dot < 9'(ppu_pkg::DOTS_PER_LINE));

endmodule

/* rtl/bg_fetcher.sv */
// three back-to-back vram reads per tile, one-cycle read latency assumed; stalls under back-pressure
`timescale 1ns/100ps

module bg_fetcher (
    input  logic                  clk,
    input  logic                  rst,
    input  ppu_pkg::ppu_cfg_t     cfg,
    input  ppu_pkg::line_status_t status,
    input  logic                  line_done,
    input  logic                  row_ready,
    input  logic [7:0]            vram_data,
    output logic                  vram_rd,
    output logic [15:0]           vram_addr,
    output ppu_pkg::bg_row_t      row,
    output logic                  row_valid
);

    typedef enum logic [2:0] {
        st_idle,
        st_map,    // map byte read issued
        st_lo,     // map byte back, low plane read issued
        st_hi,     // low plane back, high plane read issued
        st_cap,    // high plane back
        st_push    // row offered to shifter
    } fetch_state_e;

    fetch_state_e         state;
    logic [4:0]           col;
    logic [7:0]           bg_y;
    logic [15:0]          map_addr;
    logic [15:0]          tile_base;
    logic [15:0]          tile_off;
    logic [15:0]          data_addr;
    logic [15:0]          data_addr_q;
    ppu_pkg::tile_index_u tile_idx;
    ppu_pkg::bg_row_t     row_q;
    logic                 drawing;

    assign drawing = (status.mode == ppu_pkg::mode_draw);
    assign bg_y    = status.ly + cfg.scy;   // wraps at 256

    assign map_addr = (cfg.lcdc.bg_map_sel ? ppu_pkg::MAP_HIGH_BASE : ppu_pkg::MAP_LOW_BASE)
                    + {6'b0, bg_y[7:3], col};

    assign tile_idx.idx_u = vram_data;
    assign tile_base = cfg.lcdc.tile_data_sel ? ppu_pkg::TILE_DATA_UNSIGNED_BASE
                                              : ppu_pkg::TILE_DATA_SIGNED_BASE;
    assign tile_off  = cfg.lcdc.tile_data_sel ? {4'b0, tile_idx.idx_u, 4'b0}
                                              : {{4{tile_idx.idx_s[7]}}, tile_idx.idx_s, 4'b0};
    assign data_addr = tile_base + tile_off + {12'b0, bg_y[2:0], 1'b0};

    always_comb begin
        vram_rd   = 1'b0;
        vram_addr = map_addr;
        case (state)
            st_map: begin
                vram_rd   = 1'b1;
                vram_addr = map_addr;
            end
            st_lo: begin
                vram_rd   = 1'b1;
                vram_addr = data_addr;   // index taken straight off the bus
            end
            st_hi: begin
                vram_rd   = 1'b1;
                vram_addr = data_addr_q + 16'd1;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= st_idle;
            row_valid <= 1'b0;
            col       <= '0;
        end else if (line_done || !drawing) begin
            state     <= st_idle;
            row_valid <= 1'b0;   // pending row dropped at end of line
            if (status.line_start) begin
                col <= cfg.scx[7:3];
            end
        end else begin
            case (state)
                st_idle: state <= st_map;
                st_map:  state <= st_lo;
                st_lo:   state <= st_hi;
                st_hi:   state <= st_cap;
                st_cap: begin
                    row_valid <= 1'b1;
                    col       <= col + 5'd1;   // wraps at 32 tiles
                    state     <= st_push;
                end
                st_push: begin
                    if (row_ready) begin
                        row_valid <= 1'b0;
                        state     <= st_map;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // row_q only changes while no row is offered
    always_ff @(posedge clk) begin
        if (state == st_lo) begin
            data_addr_q <= data_addr;
        end
        if (state == st_hi) begin
            row_q.lo <= vram_data;
        end
        if (state == st_cap) begin
            row_q.hi <= cfg.lcdc.bg_on ? vram_data : 8'h00;
            if (!cfg.lcdc.bg_on) begin
                row_q.lo <= 8'h00;   // background off shows colour 0
            end
        end
    end

    assign row = row_q;

    a_vram_window: assert property (@(posedge clk) disable iff (rst)
        vram_rd |-> (vram_addr >= 16'h8000 && vram_addr <= 16'h9FFF));

endmodule

/* rtl/pixel_shifter.sv */
// one pixel per clock, no output back-pressure; first SCX mod 8 pixels of a line are dropped
`timescale 1ns/100ps

module pixel_shifter (
    input  logic                  clk,
    input  logic                  rst,
    input  ppu_pkg::ppu_cfg_t     cfg,
    input  ppu_pkg::line_status_t status,
    input  ppu_pkg::bg_row_t      row,
    input  logic                  row_valid,
    output logic                  row_ready,
    output logic [1:0]            pixel,
    output logic                  pixel_valid,
    output logic                  line_done
);

    logic [7:0] lo_sr;
    logic [7:0] hi_sr;
    logic [3:0] bits_left;
    logic [2:0] discard;     // fine-scroll pixels still to drop
    logic [7:0] px_count;
    logic       active;
    logic       running;
    logic       shift_now;
    logic       load;
    logic [1:0] color_idx;

    assign running   = active && (px_count != 8'(ppu_pkg::SCREEN_WIDTH));
    assign shift_now = running && (bits_left != 4'd0);
    assign row_ready = running && (bits_left <= 4'd1);   // empty, or last bit leaves now
    assign load      = row_valid && row_ready;
    assign color_idx = {hi_sr[7], lo_sr[7]};

    always_ff @(posedge clk) begin
        if (rst) begin
            bits_left   <= '0;
            discard     <= '0;
            px_count    <= '0;
            active      <= 1'b0;
            pixel_valid <= 1'b0;
            line_done   <= 1'b0;
        end else begin
            line_done   <= active && (px_count == 8'(ppu_pkg::SCREEN_WIDTH));
            pixel_valid <= shift_now && (discard == 3'd0);
            if (status.line_start) begin
                bits_left <= '0;
                discard   <= cfg.scx[2:0];
                px_count  <= '0;
                active    <= 1'b1;
            end else begin
                if (active && px_count == 8'(ppu_pkg::SCREEN_WIDTH)) begin
                    active <= 1'b0;
                end
                if (load) begin
                    bits_left <= 4'd8;
                end else if (shift_now) begin
                    bits_left <= bits_left - 4'd1;
                end
                if (shift_now) begin
                    if (discard != 3'd0) discard <= discard - 3'd1;
                    else px_count <= px_count + 8'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            lo_sr <= row.lo;
            hi_sr <= row.hi;
        end else if (shift_now) begin
            lo_sr <= {lo_sr[6:0], 1'b0};   // msb is leftmost pixel
            hi_sr <= {hi_sr[6:0], 1'b0};
        end
        if (shift_now) begin
            pixel <= cfg.bgp[{color_idx, 1'b0} +: 2];
        end
    end

    // a loaded row drains for eight clocks before the next one may come in
    a_no_early_load: assert property (@(posedge clk) disable iff (rst)
        load |=> !load [*7]);

endmodule

/* rtl/ppu_top.sv */
// background path only; VISIBLE_LINES and LINES_PER_FRAME may be shortened for simulation
`timescale 1ns/100ps

module ppu_top #(
    parameter int VISIBLE_LINES   = ppu_pkg::DEFAULT_VISIBLE_LINES,
    parameter int LINES_PER_FRAME = ppu_pkg::DEFAULT_LINES_PER_FRAME
) (
    input  logic        clk,
    input  logic        rst,
    input  logic [15:0] addr,
    input  logic        wr,
    input  logic        rd,
    input  logic [7:0]  wdata,
    output logic [7:0]  rdata,
    output logic        vram_rd,
    output logic [15:0] vram_addr,
    input  logic [7:0]  vram_data,
    output logic [1:0]  pixel,
    output logic        pixel_valid,
    output logic        irq_vblank,
    output logic        irq_stat
);

    ppu_pkg::ppu_cfg_t     cfg;
    ppu_pkg::line_status_t status;
    ppu_pkg::bg_row_t      row;
    logic                  row_valid;
    logic                  row_ready;
    logic                  line_done;

    ppu_regs ppu_regs_i (
        .clk        (clk),
        .rst        (rst),
        .addr       (addr),
        .wr         (wr),
        .rd         (rd),
        .wdata      (wdata),
        .status     (status),
        .rdata      (rdata),
        .cfg        (cfg),
        .irq_vblank (irq_vblank),
        .irq_stat   (irq_stat)
    );

    ppu_line_timer #(
        .VISIBLE_LINES   (VISIBLE_LINES),
        .LINES_PER_FRAME (LINES_PER_FRAME)
    ) ppu_line_timer_i (
        .clk       (clk),
        .rst       (rst),
        .cfg       (cfg),
        .line_done (line_done),
        .status    (status)
    );

    bg_fetcher bg_fetcher_i (
        .clk       (clk),
        .rst       (rst),
        .cfg       (cfg),
        .status    (status),
        .line_done (line_done),
        .row_ready (row_ready),
        .vram_data (vram_data),
        .vram_rd   (vram_rd),
        .vram_addr (vram_addr),
        .row       (row),
        .row_valid (row_valid)
    );

    pixel_shifter pixel_shifter_i (
        .clk         (clk),
        .rst         (rst),
        .cfg         (cfg),
        .status      (status),
        .row         (row),
        .row_valid   (row_valid),
        .row_ready   (row_ready),
        .pixel       (pixel),
        .pixel_valid (pixel_valid),
        .line_done   (line_done)
    );

endmodule

/* verification/ppu_tb_tasks.svh */
// included inside ppu_tb; a bus read takes one clock and samples rdata at the falling edge

task automatic bus_write(input logic [15:0] a, input logic [7:0] d);
    @(posedge clk);
    addr  <= a;
    wdata <= d;
    wr    <= 1'b1;
    rd    <= 1'b0;
    @(posedge clk);
    wr    <= 1'b0;   // write lands on this edge
endtask

task automatic bus_read(input logic [15:0] a, output logic [7:0] d);
    @(posedge clk);
    addr <= a;
    rd   <= 1'b1;
    wr   <= 1'b0;
    @(negedge clk);
    d = rdata;   // combinational, settled mid-cycle
endtask

task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
    if (got !== exp) begin
        $display("[FAIL] %0t: %s is %02h, expected %02h", $time, what, got, exp);
        abort_run();
    end
endtask

task automatic check_shade(input logic [1:0] got, input logic [1:0] exp, input string what);
    if (got !== exp) begin
        $display("[FAIL] %0t: %s shade is %0d, expected %0d", $time, what, got, exp);
        abort_run();
    end
endtask

task automatic check_mode(input ppu_pkg::ppu_mode_e got, input ppu_pkg::ppu_mode_e exp,
                          input string what);
    if (got !== exp) begin
        $display("[FAIL] %0t: %s is mode %0d, expected mode %0d", $time, what, got, exp);
        abort_run();
    end
endtask

task automatic check_count(input int got, input int exp, input string what);
    if (got != exp) begin
        $display("[FAIL] %0t: %s is %0d, expected %0d", $time, what, got, exp);
        abort_run();
    end
endtask

// polls LY once per clock until it reads want
task automatic wait_ly(input logic [7:0] want, input int limit);
    logic [7:0] v;
    int         n;
    n = 0;
    bus_read(ppu_pkg::REG_LY, v);
    while (v !== want) begin
        if (n >= limit) begin
            $display("LY did not reach %0d within %0d clocks", want, limit);
            abort_run();
        end
        n++;
        bus_read(ppu_pkg::REG_LY, v);
    end
endtask

// polls STAT until the coincidence bit equals want, checking irq_stat on every read
task automatic wait_coincidence(input logic want, input logic irq_on, input int limit);
    logic [7:0] d;
    int         n;
    n = 0;
    bus_read(ppu_pkg::REG_STAT, d);
    check_byte({7'b0, irq_stat}, {7'b0, irq_on & d[2]}, "irq_stat");
    while (d[2] !== want) begin
        if (n >= limit) begin
            $display("STAT coincidence bit did not become %0d within %0d clocks", want, limit);
            abort_run();
        end
        n++;
        bus_read(ppu_pkg::REG_STAT, d);
        check_byte({7'b0, irq_stat}, {7'b0, irq_on & d[2]}, "irq_stat");
    end
endtask

// gathers every valid pixel from the start of a line until LY moves on
task automatic collect_line(input logic [7:0] line);
    logic [7:0] v;
    int         n;
    pix_q.delete();
    wait_ly(line, FRAME_LIMIT);
    n = 0;
    v = line;
    while (v === line) begin
        if (n >= LINE_CLOCKS + 4) begin
            $display("line %0d did not end within %0d clocks", line, LINE_CLOCKS + 4);
            abort_run();
        end
        if (pixel_valid) pix_q.push_back(pixel);
        n++;
        bus_read(ppu_pkg::REG_LY, v);
    end
endtask

task automatic write_readback(input logic [15:0] a, input logic [7:0] v, input string what);
    logic [7:0] d;
    bus_write(a, v);
    bus_read(a, d);
    check_byte(d, v, what);
endtask

task automatic test_registers();
    logic [7:0] lyc_v;
    logic [7:0] stat_w;
    logic [7:0] d;
    write_readback(ppu_pkg::REG_LCDC, 8'(take_bits(8)) & 8'h7F, "LCDC");   // lcd stays off
    write_readback(ppu_pkg::REG_SCY, 8'(take_bits(8)), "SCY");
    write_readback(ppu_pkg::REG_SCX, 8'(take_bits(8)), "SCX");
    write_readback(ppu_pkg::REG_BGP, 8'(take_bits(8)), "BGP");
    lyc_v = 8'(take_bits(8));
    write_readback(ppu_pkg::REG_LYC, lyc_v, "LYC");
    stat_w = 8'(take_bits(8)) | 8'h07;
    bus_write(ppu_pkg::REG_STAT, stat_w);
    bus_read(ppu_pkg::REG_STAT, d);
    check_byte(d, {1'b1, stat_w[6:3], lyc_v == 8'd0, 2'b00}, "STAT");   // off: LY 0, hblank
    bus_write(ppu_pkg::REG_LY, 8'hA5);
    bus_read(ppu_pkg::REG_LY, d);
    check_byte(d, 8'h00, "LY after write");
    bus_read(16'hFF46, d);
    check_byte(d, 8'hFF, "unmapped FF46h");
    bus_read(16'hFF48, d);
    check_byte(d, 8'hFF, "unmapped FF48h");
    bus_read(16'h0000, d);
    check_byte(d, 8'hFF, "unmapped 0000h");
endtask

task automatic test_line_timing();
    logic [7:0]  ly_exp;
    logic [7:0]  d;
    int unsigned last;
    int          i;
    bus_write(ppu_pkg::REG_STAT, 8'h00);
    bus_write(ppu_pkg::REG_LCDC, 8'h80);
    wait_ly(8'd1, LINE_CLOCKS + 100);
    last   = cycle;
    ly_exp = 8'd1;
    for (i = 0; i < LINES; i++) begin
        ly_exp = (ly_exp == 8'(LINES - 1)) ? 8'd0 : ly_exp + 8'd1;
        wait_ly(ly_exp, LINE_CLOCKS + 4);
        check_count(int'(cycle - last), LINE_CLOCKS, "clocks per line");
        last = cycle;
        bus_read(ppu_pkg::REG_STAT, d);
        check_mode(ppu_pkg::ppu_mode_e'(d[1:0]),
                   (ly_exp < VISIBLE) ? ppu_pkg::mode_scan : ppu_pkg::mode_vblank,
                   $sformatf("STAT at start of line %0d", ly_exp));
        check_byte({7'b0, irq_vblank}, {7'b0, ly_exp >= VISIBLE}, "irq_vblank");
    end
endtask

task automatic test_coincidence(input logic [7:0] lyc_v, input logic irq_on);
    logic [7:0]  d;
    int unsigned rise;
    bus_write(ppu_pkg::REG_STAT, irq_on ? 8'h40 : 8'h00);
    bus_write(ppu_pkg::REG_LYC, lyc_v);
    wait_ly(lyc_v - 8'd1, FRAME_LIMIT);
    wait_coincidence(1'b1, irq_on, LINE_CLOCKS + 4);
    rise = cycle;
    bus_read(ppu_pkg::REG_LY, d);
    check_byte(d, lyc_v, "LY when coincidence sets");
    wait_coincidence(1'b0, irq_on, LINE_CLOCKS + 4);
    check_count(int'(cycle - rise), LINE_CLOCKS, "clocks with coincidence set");
    bus_read(ppu_pkg::REG_LY, d);
    check_byte(d, lyc_v + 8'd1, "LY when coincidence clears");
endtask

task automatic test_bg_pixels(input logic tile_unsigned, input logic map_high);
    logic [7:0] scx_v;
    logic [7:0] scy_v;
    logic [7:0] bgp_v;
    logic [7:0] line;
    int         i;
    bus_write(ppu_pkg::REG_LCDC, 8'h00);   // frame restarts at line 0
    repeat (10) @(posedge clk);
    for (i = 0; i < 8192; i++) vram[i] = 8'(take_bits(8));
    scx_v = 8'(take_bits(8));
    scy_v = 8'(take_bits(8));
    bgp_v = 8'(take_bits(8));
    line  = 8'(take_bits(8) % VISIBLE);
    bus_write(ppu_pkg::REG_SCX, scx_v);
    bus_write(ppu_pkg::REG_SCY, scy_v);
    bus_write(ppu_pkg::REG_BGP, bgp_v);
    bus_write(ppu_pkg::REG_LCDC, {1'b1, 2'b00, tile_unsigned, map_high, 2'b00, 1'b1});
    collect_line(line);
    check_count(pix_q.size(), 160, $sformatf("valid pixels in line %0d", line));
    for (i = 0; i < 160; i++) begin
        check_shade(pix_q[i],
                    bg_shade(i, line, scx_v, scy_v, bgp_v, tile_unsigned, map_high),
                    $sformatf("pixel %0d of line %0d", i, line));
    end
endtask

task automatic test_bg_off();
    logic [7:0] bgp_v;
    logic [7:0] line;
    int         k;
    int         i;
    bus_write(ppu_pkg::REG_LCDC, 8'h00);
    repeat (10) @(posedge clk);
    bgp_v = 8'(take_bits(8));
    line  = 8'(take_bits(8) % (VISIBLE - 1));
    bus_write(ppu_pkg::REG_BGP, bgp_v);
    bus_write(ppu_pkg::REG_SCX, 8'(take_bits(8)));
    bus_write(ppu_pkg::REG_LCDC, 8'h90);   // lcd on, background off
    for (k = 0; k < 2; k++) begin
        collect_line(line + 8'(k));
        check_count(pix_q.size(), 160, $sformatf("valid pixels in line %0d", line + k));
        for (i = 0; i < 160; i++) begin
            check_shade(pix_q[i], bgp_v[1:0], $sformatf("blank pixel %0d", i));
        end
    end
endtask

/* verification/ppu_tb.sv */
// runs full 154-line frames at 40 ns per clock, so a run spans several ms; stops at the first error
`timescale 1ns/100ps

module ppu_tb;

    localparam int VISIBLE     = 144;
    localparam int LINES       = 154;
    localparam int LINE_CLOCKS = 456;
    localparam int FRAME_LIMIT = LINE_CLOCKS * LINES + 100;   // longest wait for a given LY

    logic        clk;
    logic        rst;
    logic [15:0] addr;
    logic        wr;
    logic        rd;
    logic [7:0]  wdata;
    logic [7:0]  rdata;
    logic        vram_rd;
    logic [15:0] vram_addr;
    logic [7:0]  vram_data = 8'h00;
    logic [1:0]  pixel;
    logic        pixel_valid;
    logic        irq_vblank;
    logic        irq_stat;

    logic [7:0]  vram [0:8191];   // 8000h..9fffh
    logic [31:0] lfsr_state;
    int unsigned cycle = 0;       // free-running clock count
    logic [1:0]  pix_q [$];       // valid pixels of the last collected line

    ppu_top #(
        .VISIBLE_LINES   (VISIBLE),
        .LINES_PER_FRAME (LINES)
    ) ppu_top_i (
        .clk         (clk),
        .rst         (rst),
        .addr        (addr),
        .wr          (wr),
        .rd          (rd),
        .wdata       (wdata),
        .rdata       (rdata),
        .vram_rd     (vram_rd),
        .vram_addr   (vram_addr),
        .vram_data   (vram_data),
        .pixel       (pixel),
        .pixel_valid (pixel_valid),
        .irq_vblank  (irq_vblank),
        .irq_stat    (irq_stat)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // vram answers one clock after the read strobe
    always @(posedge clk) begin
        if (vram_rd) begin
            vram_data <= vram[vram_addr[12:0]];
        end
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per bit handed out
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            v          = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return v;
    endfunction

    // shade at screen column x of a line, from the map, tile data and palette held in vram
    function automatic logic [1:0] bg_shade(input int x, input logic [7:0] line,
                                            input logic [7:0] scx, input logic [7:0] scy,
                                            input logic [7:0] bgp, input logic tile_unsigned,
                                            input logic map_high);
        logic [7:0] bg_x;
        logic [7:0] bg_y;
        logic [7:0] t;
        logic [1:0] idx;
        int         map_a;
        int         tile_a;
        int         b;
        bg_x  = scx + 8'(x);   // both scroll sums wrap at 256
        bg_y  = line + scy;
        map_a = (map_high ? 'h9C00 : 'h9800) + int'(bg_y / 8) * 32 + int'(bg_x / 8);
        t     = vram[map_a - 'h8000];
        if (tile_unsigned) tile_a = 'h8000 + int'(t) * 16;
        else tile_a = 'h9000 + int'($signed(t)) * 16;
        tile_a = tile_a + int'(bg_y % 8) * 2 - 'h8000;
        b      = 7 - int'(bg_x % 8);   // leftmost pixel in bit 7
        idx    = {vram[tile_a + 1][b], vram[tile_a][b]};
        return bgp[2 * int'(idx) +: 2];
    endfunction

    task automatic abort_run();
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped at the first error");
    endtask

    `include "ppu_tb_tasks.svh"

    initial begin
        int a;
        rst        = 1'b1;
        addr       = '0;
        wr         = 1'b0;
        rd         = 1'b0;
        wdata      = '0;
        lfsr_state = 32'h58ec_84fa;
        for (a = 0; a < 8192; a++) begin
            vram[a] = 8'(a) ^ 8'(a >> 5);   // address-dependent fill until random data loads
        end
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        test_registers();
        test_line_timing();
        test_coincidence(8'd10, 1'b1);
        test_coincidence(8'd100, 1'b0);
        test_bg_pixels(1'b1, 1'b0);
        test_bg_pixels(1'b0, 1'b0);
        test_bg_pixels(1'b1, 1'b1);
        test_bg_pixels(1'b0, 1'b1);
        test_bg_off();
        $display("NO ERRORS");
        $finish;
    end

endmodule

/* tb.f */
+incdir+verification
rtl/ppu_pkg.sv
rtl/ppu_regs.sv
rtl/ppu_line_timer.sv
rtl/bg_fetcher.sv
rtl/pixel_shifter.sv
rtl/ppu_top.sv
verification/ppu_tb.sv

/* Bender.yml */
package:
  name: ppu_bg

sources:
  - rtl/ppu_pkg.sv
  - rtl/ppu_regs.sv
  - rtl/ppu_line_timer.sv
  - rtl/bg_fetcher.sv
  - rtl/pixel_shifter.sv
  - rtl/ppu_top.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/ppu_tb.sv
